/* rv_core_settings.svh */
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// address of the first instruction fetched after reset.
`define RV_RESET_PC 32'h0000_0000

// user-level counter CSRs readable through CSRRS.
`define RV_CSR_INSTRET 12'hC02
`define RV_CSR_INSTRETH 12'hC82

`endif

/* rv_core_pkg.sv */
package rv_core_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_word_t;

endpackage

/* fetch_fsm.sv */
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module fetch_fsm (
    input  logic        CLK,
    input  logic        reset,
    input  logic        wb_ack,
    input  logic [31:0] wb_dat_i,
    input  logic        flush,
    input  logic [31:0] redirect_pc,
    input  logic        halt,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    output logic [31:0] fetch_word,
    output logic [31:0] fetch_pc,
    output logic        halted
);

    localparam logic [1:0] ST_BOOT  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_STOP  = 2'd2;

    logic [1:0]  state;
    logic [31:0] pc;

    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= ST_BOOT;
            pc <= `RV_RESET_PC;
        end else begin
            case (state)
                ST_BOOT: begin
                    state <= ST_FETCH; // one idle cycle before the first request.
                end
                ST_FETCH: begin
                    if (wb_ack) begin
                        pc <= flush ? redirect_pc : pc + 32'd4;
                        if (halt) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    state <= ST_STOP; // only reset leaves this state.
                end
                default: begin
                    state <= ST_BOOT;
                end
            endcase
        end
    end

    assign wb_cyc = (state == ST_FETCH);
    assign wb_stb = (state == ST_FETCH);
    assign wb_we = 1'b0;
    assign wb_adr = pc;
    assign fetch_word = wb_dat_i; // decode samples this on the ack edge.
    assign fetch_pc = pc;
    assign halted = (state == ST_STOP);

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import rv_core_pkg::*; (
    input  logic        CLK,
    input  logic        reset,
    input  logic        advance,
    input  logic        flush,
    input  logic [31:0] fetch_word,
    input  logic [31:0] fetch_pc,
    output logic        dec_valid,
    output logic [31:0] dec_pc,
    output opcode_t     dec_opcode,
    output logic [4:0]  dec_rd,
    output logic [4:0]  dec_rs1,
    output logic [4:0]  dec_rs2,
    output logic [11:0] dec_csr,
    output logic [2:0]  dec_funct3,
    output logic [6:0]  dec_funct7,
    output logic [31:0] dec_imm
);

    instr_word_t word;
    logic [31:0] imm;

    assign word = fetch_word;

    always_comb begin
        case (word.r_fmt.opcode)
            LUI, AUIPC: begin
                imm = {word.u_fmt.imm_31_12, 12'd0};
            end
            JAL: begin
                imm = {{12{word.j_fmt.imm_20}}, word.j_fmt.imm_19_12, word.j_fmt.imm_11,
                       word.j_fmt.imm_10_1, 1'b0};
            end
            BRANCH: begin
                imm = {{20{word.b_fmt.imm_12}}, word.b_fmt.imm_11, word.b_fmt.imm_10_5,
                       word.b_fmt.imm_4_1, 1'b0};
            end
            default: begin
                imm = {{20{word.i_fmt.imm[11]}}, word.i_fmt.imm}; // I-type covers OP-IMM, JALR, SYSTEM.
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            dec_valid <= 1'b0;
            dec_pc <= 32'd0;
            dec_opcode <= opcode_t'(7'd0);
            dec_rd <= 5'd0;
            dec_rs1 <= 5'd0;
            dec_rs2 <= 5'd0;
            dec_csr <= 12'd0;
            dec_funct3 <= 3'd0;
            dec_funct7 <= 7'd0;
            dec_imm <= 32'd0;
        end else if (advance) begin
            dec_valid <= 1'b1;
            dec_pc <= fetch_pc;
            dec_opcode <= word.r_fmt.opcode;
            dec_rd <= word.r_fmt.rd;
            dec_rs1 <= word.r_fmt.rs1;
            dec_rs2 <= word.r_fmt.rs2;
            dec_csr <= word.i_fmt.imm;
            dec_funct3 <= word.r_fmt.funct3;
            dec_funct7 <= word.r_fmt.funct7;
            dec_imm <= imm;
        end
    end

endmodule

/* schedule_stage.sv */
`timescale 1ns/1ps

module schedule_stage import rv_core_pkg::*; (
    input  logic        CLK,
    input  logic        reset,
    input  logic        advance,
    input  logic        flush,
    input  logic        dec_valid,
    input  logic [31:0] dec_pc,
    input  opcode_t     dec_opcode,
    input  logic [4:0]  dec_rd,
    input  logic [4:0]  dec_rs1,
    input  logic [4:0]  dec_rs2,
    input  logic [11:0] dec_csr,
    input  logic [2:0]  dec_funct3,
    input  logic [6:0]  dec_funct7,
    input  logic [31:0] dec_imm,
    output logic        sch_valid,
    output logic [31:0] sch_pc,
    output opcode_t     sch_opcode,
    output logic [4:0]  sch_rd,
    output logic [4:0]  sch_rs1,
    output logic [4:0]  sch_rs2,
    output logic [11:0] sch_csr,
    output logic [2:0]  sch_funct3,
    output logic [6:0]  sch_funct7,
    output logic [31:0] sch_imm
);

    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            sch_valid <= 1'b0;
            sch_pc <= 32'd0;
            sch_opcode <= opcode_t'(7'd0);
            sch_rd <= 5'd0;
            sch_rs1 <= 5'd0;
            sch_rs2 <= 5'd0;
            sch_csr <= 12'd0;
            sch_funct3 <= 3'd0;
            sch_funct7 <= 7'd0;
            sch_imm <= 32'd0;
        end else if (advance) begin // hold while the fetch is still waiting.
            sch_valid <= dec_valid;
            sch_pc <= dec_pc;
            sch_opcode <= dec_opcode;
            sch_rd <= dec_rd;
            sch_rs1 <= dec_rs1;
            sch_rs2 <= dec_rs2;
            sch_csr <= dec_csr;
            sch_funct3 <= dec_funct3;
            sch_funct7 <= dec_funct7;
            sch_imm <= dec_imm;
        end
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module execute_stage import rv_core_pkg::*; (
    input  logic        CLK,
    input  logic        reset,
    input  logic        advance,
    input  logic        sch_valid,
    input  logic [31:0] sch_pc,
    input  opcode_t     sch_opcode,
    input  logic [4:0]  sch_rd,
    input  logic [4:0]  sch_rs1,
    input  logic [4:0]  sch_rs2,
    input  logic [11:0] sch_csr,
    input  logic [2:0]  sch_funct3,
    input  logic [6:0]  sch_funct7,
    input  logic [31:0] sch_imm,
    input  logic [63:0] instret,
    output logic        flush,
    output logic [31:0] redirect_pc,
    output logic        halt,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_data
);

    logic [31:0] regs [1:31];
    logic [31:0] rs1_val, rs2_val, op_b, alu_out, sra_out, pc_imm, link, result, target;
    logic        cond, jump, is_ebreak, wr_en, rd_write;

    assign rs1_val = (sch_rs1 == 5'd0) ? 32'd0 : regs[sch_rs1];
    assign rs2_val = (sch_rs2 == 5'd0) ? 32'd0 : regs[sch_rs2];
    assign op_b = (sch_opcode == OP) ? rs2_val : sch_imm;
    assign sra_out = $signed(rs1_val) >>> op_b[4:0];
    assign pc_imm = sch_pc + sch_imm;
    assign link = sch_pc + 32'd4;

    always_comb begin
        case (sch_funct3)
            3'b000: alu_out = (sch_opcode == OP && sch_funct7[5]) ? rs1_val - op_b
                                                                  : rs1_val + op_b;
            3'b001: alu_out = rs1_val << op_b[4:0];
            3'b010: alu_out = {31'd0, $signed(rs1_val) < $signed(op_b)};
            3'b011: alu_out = {31'd0, rs1_val < op_b};
            3'b100: alu_out = rs1_val ^ op_b;
            3'b101: alu_out = sch_funct7[5] ? sra_out : rs1_val >> op_b[4:0];
            3'b110: alu_out = rs1_val | op_b;
            default: alu_out = rs1_val & op_b;
        endcase
        case (sch_funct3)
            3'b000: cond = (rs1_val == rs2_val);
            3'b001: cond = (rs1_val != rs2_val);
            3'b100: cond = ($signed(rs1_val) < $signed(rs2_val));
            3'b101: cond = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110: cond = (rs1_val < rs2_val);
            3'b111: cond = (rs1_val >= rs2_val);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        result = 32'd0;
        wr_en = 1'b0;
        jump = 1'b0;
        is_ebreak = 1'b0;
        target = pc_imm;
        case (sch_opcode)
            OP, OP_IMM: begin
                result = alu_out;
                wr_en = 1'b1;
            end
            LUI: begin
                result = sch_imm;
                wr_en = 1'b1;
            end
            AUIPC: begin
                result = pc_imm;
                wr_en = 1'b1;
            end
            JAL: begin
                result = link;
                wr_en = 1'b1;
                jump = 1'b1;
            end
            JALR: begin
                result = link;
                wr_en = 1'b1;
                jump = 1'b1;
                target = (rs1_val + sch_imm) & ~32'd1;
            end
            BRANCH: begin
                jump = cond;
            end
            SYSTEM: begin
                if (sch_funct3 == 3'b010 && sch_rs1 == 5'd0) begin // CSRRS rd, csr, x0.
                    if (sch_csr == `RV_CSR_INSTRET) begin
                        result = instret[31:0];
                        wr_en = 1'b1;
                    end else if (sch_csr == `RV_CSR_INSTRETH) begin
                        result = instret[63:32];
                        wr_en = 1'b1;
                    end
                end else if (sch_funct3 == 3'b000 && sch_csr == 12'h001) begin
                    is_ebreak = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assign rd_write = wr_en && (sch_rd != 5'd0);

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (retire_valid && rd_write) begin
            regs[sch_rd] <= result;
        end
    end

    assign retire_valid = advance && sch_valid;
    assign retire_pc = sch_pc;
    assign retire_rd = rd_write ? sch_rd : 5'd0;
    assign retire_data = rd_write ? result : 32'd0;
    assign flush = retire_valid && (jump || is_ebreak);
    assign redirect_pc = target;
    assign halt = retire_valid && is_ebreak;

endmodule

/* retire_counter.sv */
`timescale 1ns/1ps

module retire_counter (
    input  logic        CLK,
    input  logic        reset,
    input  logic        retire_valid,
    output logic [63:0] instret
);

    // the current instruction sees the count before its own retire.
    always_ff @(posedge CLK) begin
        if (reset) begin
            instret <= 64'd0;
        end else if (retire_valid) begin
            instret <= instret + 64'd1;
        end
    end

endmodule

/* rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; (
    input  logic        CLK,
    input  logic        reset,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_data,
    output logic        halted
);

    logic        advance, flush, halt;
    logic [31:0] redirect_pc, fetch_word, fetch_pc;
    logic [63:0] instret;

    logic        dec_valid, sch_valid;
    logic [31:0] dec_pc, dec_imm, sch_pc, sch_imm;
    opcode_t     dec_opcode, sch_opcode;
    logic [4:0]  dec_rd, dec_rs1, dec_rs2, sch_rd, sch_rs1, sch_rs2;
    logic [11:0] dec_csr, sch_csr;
    logic [2:0]  dec_funct3, sch_funct3;
    logic [6:0]  dec_funct7, sch_funct7;

    assign advance = wb_ack && wb_cyc; // every stage moves only on an acked fetch.

    fetch_fsm fetch_i (
        .CLK(CLK), .reset(reset), .wb_ack(wb_ack), .wb_dat_i(wb_dat_i),
        .flush(flush), .redirect_pc(redirect_pc), .halt(halt),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .fetch_word(fetch_word), .fetch_pc(fetch_pc), .halted(halted)
    );

    decode_stage decode_i (
        .CLK(CLK), .reset(reset), .advance(advance), .flush(flush),
        .fetch_word(fetch_word), .fetch_pc(fetch_pc),
        .dec_valid(dec_valid), .dec_pc(dec_pc), .dec_opcode(dec_opcode), .dec_rd(dec_rd),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_csr(dec_csr), .dec_funct3(dec_funct3),
        .dec_funct7(dec_funct7), .dec_imm(dec_imm)
    );

    schedule_stage schedule_i (
        .CLK(CLK), .reset(reset), .advance(advance), .flush(flush),
        .dec_valid(dec_valid), .dec_pc(dec_pc), .dec_opcode(dec_opcode), .dec_rd(dec_rd),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_csr(dec_csr), .dec_funct3(dec_funct3),
        .dec_funct7(dec_funct7), .dec_imm(dec_imm),
        .sch_valid(sch_valid), .sch_pc(sch_pc), .sch_opcode(sch_opcode), .sch_rd(sch_rd),
        .sch_rs1(sch_rs1), .sch_rs2(sch_rs2), .sch_csr(sch_csr), .sch_funct3(sch_funct3),
        .sch_funct7(sch_funct7), .sch_imm(sch_imm)
    );

    execute_stage execute_i (
        .CLK(CLK), .reset(reset), .advance(advance),
        .sch_valid(sch_valid), .sch_pc(sch_pc), .sch_opcode(sch_opcode), .sch_rd(sch_rd),
        .sch_rs1(sch_rs1), .sch_rs2(sch_rs2), .sch_csr(sch_csr), .sch_funct3(sch_funct3),
        .sch_funct7(sch_funct7), .sch_imm(sch_imm), .instret(instret),
        .flush(flush), .redirect_pc(redirect_pc), .halt(halt),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    retire_counter counter_i (
        .CLK(CLK), .reset(reset), .retire_valid(retire_valid), .instret(instret)
    );

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module tb_rv_core import rv_core_pkg::*; ();

    logic        CLK = 1'b0;
    logic        reset = 1'b1;
    logic        wb_ack = 1'b0;
    logic [31:0] wb_dat_i = 32'd0;
    logic        wb_cyc, wb_stb, wb_we, retire_valid, halted;
    logic [31:0] wb_adr, retire_pc, retire_data;
    logic [4:0]  retire_rd;

    logic [31:0] mem [0:255];
    logic [31:0] m_regs [0:31];
    logic [31:0] m_pc, sig, exp_pc, exp_data;
    logic [63:0] m_count;
    logic [4:0]  exp_rd;
    logic        m_halted;
    logic [31:0] rng = 32'h555382d4;
    logic [1:0]  wait_left = 2'd0;
    logic        random_waits = 1'b0;
    int          trace_checks = 0;
    int          trace_errors = 0;
    int          flow_checks = 0;
    int          flow_errors = 0;
    int          wr_idx = 0;
    string       test_name = "none";

    always #2 CLK = ~CLK;

    rv_core_top dut_i (
        .CLK(CLK), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data), .halted(halted)
    );

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // wishbone slave with 0 to 3 wait cycles and a registered ack.
    always @(posedge CLK) begin
        if (reset) begin
            wb_ack <= 1'b0;
            wait_left <= 2'd0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
            rng <= xorshift(rng);
            wait_left <= random_waits ? rng[1:0] : 2'd0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_left == 2'd0) begin
                wb_ack <= 1'b1;
                wb_dat_i <= mem[wb_adr[9:2]];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    // the master only reads, and stb travels with cyc.
    always @(posedge CLK) begin
        if (!reset) begin
            flow_checks++;
            assert (wb_stb == wb_cyc && !wb_we) else begin
                flow_errors++;
                $display("%s: stb does not follow cyc or we is high", test_name);
            end
        end
    end

    function automatic logic [31:0] r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        instr_word_t w;
        w.r_fmt = '{f7, rs2, rs1, f3, rd, OP};
        return w;
    endfunction

    function automatic logic [31:0] i_word(opcode_t op, logic [11:0] imm, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        instr_word_t w;
        w.i_fmt = '{imm, rs1, f3, rd, op};
        return w;
    endfunction

    function automatic logic [31:0] u_word(opcode_t op, logic [19:0] imm, logic [4:0] rd);
        instr_word_t w;
        w.u_fmt = '{imm, rd, op};
        return w;
    endfunction

    function automatic logic [31:0] b_word(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        instr_word_t w;
        w.b_fmt = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
        return w;
    endfunction

    function automatic logic [31:0] j_word(logic [20:0] off, logic [4:0] rd);
        instr_word_t w;
        w.j_fmt = '{off[20], off[10:1], off[11], off[19:12], rd, JAL};
        return w;
    endfunction

    // steps the instruction-set model by one instruction and returns what it retires.
    function automatic void ref_step(output logic [31:0] e_pc, output logic [4:0] e_rd,
                                     output logic [31:0] e_data);
        logic [31:0] iw, a, r2, b, imm, res, next;
        logic [2:0]  f3;
        logic        wr, take;
        iw = mem[m_pc[9:2]];
        f3 = iw[14:12];
        a = m_regs[iw[19:15]];
        r2 = m_regs[iw[24:20]];
        imm = {{20{iw[31]}}, iw[31:20]};
        b = (iw[6:0] == OP) ? r2 : imm;
        res = 32'd0;
        wr = 1'b1;
        take = 1'b0;
        next = m_pc + 32'd4;
        case (iw[6:0])
            OP, OP_IMM: begin
                case (f3)
                    3'd0: res = (iw[6:0] == OP && iw[30]) ? a - b : a + b;
                    3'd1: res = a << b[4:0];
                    3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd3: res = (a < b) ? 32'd1 : 32'd0;
                    3'd4: res = a ^ b;
                    3'd5: begin
                        if (iw[30]) res = $signed(a) >>> b[4:0];
                        else res = a >> b[4:0];
                    end
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
            end
            LUI: res = {iw[31:12], 12'd0};
            AUIPC: res = m_pc + {iw[31:12], 12'd0};
            JAL: begin
                res = next;
                next = m_pc + {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
            end
            JALR: begin
                res = next;
                next = (a + imm) & ~32'd1; // target uses rs1 before rd is written.
            end
            BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'd0: take = (a == r2);
                    3'd1: take = (a != r2);
                    3'd4: take = ($signed(a) < $signed(r2));
                    3'd5: take = ($signed(a) >= $signed(r2));
                    3'd6: take = (a < r2);
                    3'd7: take = (a >= r2);
                    default: take = 1'b0;
                endcase
                if (take) next = m_pc + {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
            end
            SYSTEM: begin
                wr = (f3 == 3'd2 && iw[19:15] == 5'd0 &&
                      (iw[31:20] == `RV_CSR_INSTRET || iw[31:20] == `RV_CSR_INSTRETH));
                res = (iw[31:20] == `RV_CSR_INSTRETH) ? m_count[63:32] : m_count[31:0];
                if (f3 == 3'd0 && iw[31:20] == 12'h001) m_halted = 1'b1;
            end
            default: wr = 1'b0;
        endcase
        e_pc = m_pc;
        e_rd = (wr && iw[11:7] != 5'd0) ? iw[11:7] : 5'd0;
        e_data = (e_rd != 5'd0) ? res : 32'd0;
        if (e_rd != 5'd0) m_regs[e_rd] = res;
        m_pc = next;
        m_count = m_count + 64'd1;
    endfunction

    always @(posedge CLK) begin
        if (reset) begin
            m_pc = `RV_RESET_PC;
            m_count = 64'd0;
            m_halted = 1'b0;
            sig = 32'd0;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = 32'd0;
            end
        end else if (retire_valid) begin
            trace_checks++;
            assert (!m_halted) else begin
                trace_errors++;
                $display("%s: instruction at %h retired after EBREAK", test_name, retire_pc);
            end
            if (!m_halted) begin
                ref_step(exp_pc, exp_rd, exp_data);
                assert (retire_pc == exp_pc) else begin
                    trace_errors++;
                    $display("error %s pc: expected %h actual %h", test_name, exp_pc, retire_pc);
                end
                assert (retire_rd == exp_rd) else begin
                    trace_errors++;
                    $display("error %s rd at %h: expected %0d actual %0d", test_name, exp_pc,
                             exp_rd, retire_rd);
                end
                assert (retire_data == exp_data) else begin
                    trace_errors++;
                    $display("error %s data at %h: expected %h actual %h", test_name, exp_pc,
                             exp_data, retire_data);
                end
            end
            sig = {sig[30:0], sig[31]} ^ retire_pc ^ retire_data ^ {27'd0, retire_rd};
        end
    end

    task automatic emit(input logic [31:0] w);
        mem[wr_idx] = w;
        wr_idx++;
    endtask

    task automatic clear_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[11:0], 20'h00013}; // addi into x0 with the word index as immediate.
        end
        wr_idx = `RV_RESET_PC >> 2;
    endtask

    task automatic load_alu();
        clear_memory();
        emit(u_word(LUI, 20'h80000, 5'd1));
        emit(i_word(OP_IMM, 12'hffb, 5'd0, 3'd0, 5'd2)); // negative immediate.
        emit(i_word(OP_IMM, 12'h7ff, 5'd1, 3'd0, 5'd3));
        emit(r_word(7'h00, 5'd3, 5'd2, 3'd0, 5'd4));
        emit(r_word(7'h20, 5'd3, 5'd2, 3'd0, 5'd5));
        emit(i_word(OP_IMM, 12'h004, 5'd2, 3'd1, 5'd6));
        emit(i_word(OP_IMM, 12'h003, 5'd1, 3'd5, 5'd7));
        emit(i_word(OP_IMM, 12'h403, 5'd1, 3'd5, 5'd8));
        emit(r_word(7'h00, 5'd3, 5'd2, 3'd2, 5'd9));
        emit(r_word(7'h00, 5'd3, 5'd2, 3'd3, 5'd10));
        emit(i_word(OP_IMM, 12'hfff, 5'd2, 3'd2, 5'd11));
        emit(i_word(OP_IMM, 12'hfff, 5'd2, 3'd3, 5'd12));
        emit(i_word(OP_IMM, 12'h555, 5'd2, 3'd4, 5'd13));
        emit(i_word(OP_IMM, 12'h8f0, 5'd3, 3'd6, 5'd14));
        emit(i_word(OP_IMM, 12'h8f0, 5'd2, 3'd7, 5'd15));
        emit(r_word(7'h00, 5'd13, 5'd2, 3'd1, 5'd16));
        emit(r_word(7'h00, 5'd6, 5'd1, 3'd5, 5'd17));
        emit(r_word(7'h20, 5'd6, 5'd1, 3'd5, 5'd18));
        emit(r_word(7'h00, 5'd14, 5'd15, 3'd4, 5'd19));
        emit(r_word(7'h00, 5'd14, 5'd15, 3'd6, 5'd20));
        emit(r_word(7'h00, 5'd14, 5'd15, 3'd7, 5'd21));
        emit(u_word(AUIPC, 20'h12345, 5'd22));
        emit(i_word(OP_IMM, 12'h007, 5'd2, 3'd0, 5'd0));
        emit(r_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd23));
        emit(32'h00a02083); // a load is outside the slice and retires as a no-op.
        emit(i_word(SYSTEM, `RV_CSR_INSTRET, 5'd0, 3'd2, 5'd24));
        emit(i_word(SYSTEM, `RV_CSR_INSTRETH, 5'd0, 3'd2, 5'd25));
        emit(i_word(SYSTEM, 12'h001, 5'd0, 3'd0, 5'd0));
    endtask

    task automatic load_flow();
        clear_memory();
        emit(i_word(OP_IMM, 12'd3, 5'd0, 3'd0, 5'd1));
        emit(i_word(OP_IMM, 12'd1, 5'd2, 3'd0, 5'd2));
        emit(i_word(OP_IMM, 12'hfff, 5'd1, 3'd0, 5'd1));
        emit(b_word(13'h1ff8, 5'd0, 5'd1, 3'd1)); // loops back twice.
        emit(b_word(13'd8, 5'd1, 5'd2, 3'd4));
        emit(b_word(13'd8, 5'd1, 5'd2, 3'd5));
        emit(i_word(OP_IMM, 12'd99, 5'd0, 3'd0, 5'd5));
        emit(b_word(13'd8, 5'd2, 5'd1, 3'd6));
        emit(i_word(OP_IMM, 12'd98, 5'd0, 3'd0, 5'd5));
        emit(b_word(13'd8, 5'd2, 5'd1, 3'd7));
        emit(b_word(13'd8, 5'd0, 5'd1, 3'd0));
        emit(i_word(OP_IMM, 12'd97, 5'd0, 3'd0, 5'd5));
        emit(j_word(21'd12, 5'd6));
        emit(i_word(OP_IMM, 12'd96, 5'd0, 3'd0, 5'd5));
        emit(i_word(OP_IMM, 12'd95, 5'd0, 3'd0, 5'd5));
        emit(i_word(JALR, 12'd13, 5'd6, 3'd0, 5'd7)); // the odd target loses bit 0.
        emit(j_word(21'd8, 5'd0));
        emit(i_word(OP_IMM, 12'd94, 5'd0, 3'd0, 5'd5));
        emit(i_word(SYSTEM, `RV_CSR_INSTRET, 5'd0, 3'd2, 5'd8));
        emit(i_word(SYSTEM, 12'h001, 5'd0, 3'd0, 5'd0));
    endtask

    task automatic run_program(input string name, input logic rand_mode,
                               output logic [31:0] run_sig);
        int n;
        test_name = name;
        random_waits <= rand_mode;
        reset <= 1'b1;
        repeat (5) @(posedge CLK);
        reset <= 1'b0;
        @(posedge CLK);
        flow_checks += 5;
        assert (!wb_cyc) else begin
            flow_errors++;
            $display("%s: cyc was high in the first cycle after reset", name);
        end
        n = 0;
        while (!wb_cyc && n < 10) begin
            @(posedge CLK);
            n++;
        end
        assert (wb_cyc) else begin
            flow_errors++;
            $display("%s: timeout waiting for the first fetch request", name);
        end
        assert (wb_adr == `RV_RESET_PC) else begin
            flow_errors++;
            $display("error %s first address: expected %h actual %h", name, `RV_RESET_PC, wb_adr);
        end
        n = 0;
        while (!halted && n < 4000) begin
            @(posedge CLK);
            n++;
        end
        assert (halted) else begin
            flow_errors++;
            $display("%s: timeout waiting for the core to halt", name);
        end
        assert (m_halted) else begin
            flow_errors++;
            $display("%s: the reference model never retired the EBREAK", name);
        end
        for (n = 0; n < 32; n++) begin
            @(posedge CLK);
            flow_checks++;
            assert (!wb_cyc && !retire_valid) else begin
                flow_errors++;
                $display("%s: bus or trace activity after the core halted", name);
            end
        end
        run_sig = sig;
    endtask

    task automatic compare_runs(input string name, input logic [31:0] zero_sig,
                                input logic [31:0] rand_sig);
        flow_checks++;
        assert (rand_sig == zero_sig) else begin
            flow_errors++;
            $display("error %s trace signature: expected %h actual %h", name, zero_sig, rand_sig);
        end
    endtask

    initial begin
        logic [31:0] sig_zero, sig_rand;
        @(posedge CLK);
        load_alu();
        run_program("alu", 1'b0, sig_zero);
        run_program("alu random wait", 1'b1, sig_rand);
        compare_runs("alu", sig_zero, sig_rand);
        load_flow();
        run_program("flow", 1'b0, sig_zero);
        run_program("flow random wait", 1'b1, sig_rand);
        compare_runs("flow", sig_zero, sig_rand);
        $display("trace checks %0d, trace errors %0d, flow checks %0d, flow errors %0d",
                 trace_checks, trace_errors, flow_checks, flow_errors);
        if (trace_errors == 0 && flow_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
rv_core_pkg.sv
fetch_fsm.sv
decode_stage.sv
schedule_stage.sv
execute_stage.sv
retire_counter.sv
rv_core_top.sv
tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then decide pass or fail from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_rv_core > build.log 2>&1 \
    && ./obj_dir/Vtb_rv_core > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qx "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
